// File: bk_mem_pkg.sv
// BK0011M memory map definitions
`default_nettype none

package bk_mem_pkg;

	localparam int BUS_AW      = 16;
	localparam int DATA_W      = 16;
	localparam int PHYS_AW     = 20;  // 1 MB of byte space
	localparam int SCR_AW      = 14;
	localparam int PAGE_SHIFT  = 14;  // 16 KB pages
	localparam int REQ_CREDITS = 4;

	typedef logic [PHYS_AW-1:0] phys_addr_t;
	typedef logic [DATA_W-1:0]  bus_word_t;
	typedef logic [2:0]         page_code_t;

	typedef enum logic [1:0] {
		ACC_READ,
		ACC_WRITE,
		ACC_SYSREG,
		ACC_ERR
	} acc_kind_e;

	localparam phys_addr_t RAM_PAGE_BASE [8] = '{
		20'h00000, 20'h04000, 20'h08000, 20'h0C000,
		20'h10000, 20'h14000, 20'h18000, 20'h1C000
	};

	localparam phys_addr_t ROM_START   = 20'hE0000;
	localparam phys_addr_t ROM_P10     = 20'hE0000;  // BASIC
	localparam phys_addr_t ROM_P11     = 20'hE4000;
	localparam phys_addr_t ROM_P12     = 20'hE8000;
	localparam phys_addr_t ROM_P13     = 20'hEC000;
	localparam phys_addr_t BIOS11_BASE = 20'hF0000;  // 8 KB window
	localparam phys_addr_t MSTD_BASE   = 20'hFE000;  // 8 KB window

	localparam logic [BUS_AW-1:0] SYSREG_ADDR = 16'o177716;
	localparam logic [BUS_AW-1:0] IO_START    = 16'o177000;
	localparam logic [BUS_AW-1:0] TOP_ADDR    = 16'o177600;

	// Screen pages, compared against physical address bits 19:14
	localparam logic [PHYS_AW-PAGE_SHIFT-1:0] SCR_PAGE_0 = 6'd5;
	localparam logic [PHYS_AW-PAGE_SHIFT-1:0] SCR_PAGE_1 = 6'd6;

	// Page register code to RAM page base
	function automatic phys_addr_t page_base(input page_code_t code);
		case (code)
			3'b110:  page_base = RAM_PAGE_BASE[0];
			3'b000:  page_base = RAM_PAGE_BASE[1];
			3'b010:  page_base = RAM_PAGE_BASE[2];
			3'b011:  page_base = RAM_PAGE_BASE[3];
			3'b100:  page_base = RAM_PAGE_BASE[4];
			3'b001:  page_base = RAM_PAGE_BASE[5];
			3'b111:  page_base = RAM_PAGE_BASE[6];
			default: page_base = RAM_PAGE_BASE[7];
		endcase
	endfunction

endpackage

`default_nettype wire

// File: bk_mem_if.sv
// Pipeline stage interfaces
`default_nettype none

// Decoded access, decode to execute
interface acc_if import bk_mem_pkg::*; ();
	logic       valid;
	logic       ready;
	acc_kind_e  kind;
	phys_addr_t phys;
	logic [1:0] be;
	bus_word_t  wdata;

	modport dec (output valid, kind, phys, be, wdata, input ready);
	modport exe (input valid, kind, phys, be, wdata, output ready);
endinterface

// Executed access, no back-pressure
interface res_if import bk_mem_pkg::*; ();
	logic       valid;
	acc_kind_e  kind;
	bus_word_t  rdata;
	phys_addr_t phys;
	logic [1:0] be;
	bus_word_t  wdata;

	modport exe (output valid, kind, rdata, phys, be, wdata);
	modport res (input valid, kind, rdata, phys, be, wdata);
endinterface

`default_nettype wire

// File: page_decode.sv
// Request queue and page translation
`default_nettype none

module page_decode import bk_mem_pkg::*; (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                req_valid,
	input  wire                req_we,
	input  wire [1:0]          req_wtbt,
	input  wire [BUS_AW-1:0]   req_addr,
	input  wire bus_word_t     req_din,
	output logic               credit_return,
	input  wire [3:0]          rom_avail,
	acc_if.dec                 acc
);

	localparam int QW = $clog2(REQ_CREDITS);

	typedef struct packed {
		logic              we;
		logic [1:0]        wtbt;
		logic [BUS_AW-1:0] addr;
		bus_word_t         din;
	} req_t;

	req_t          q_mem [REQ_CREDITS];
	logic [QW-1:0] wr_ptr, rd_ptr;
	logic [QW:0]   count;
	req_t          in_req, head;
	logic          q_empty, out_free, pop, push, deq;

	logic [15:0]   page_reg;
	logic          is_sys;
	acc_kind_e     kind;
	phys_addr_t    phys, rom_base;
	logic          rom_hit;

	assign in_req   = '{we: req_we, wtbt: req_wtbt, addr: req_addr, din: req_din};
	assign q_empty  = (count == '0);
	assign head     = q_empty ? in_req : q_mem[rd_ptr];  // Fall through when empty
	assign out_free = !acc.valid || acc.ready;
	assign pop      = out_free && (!q_empty || req_valid);
	assign deq      = pop && !q_empty;
	assign push     = req_valid && !(q_empty && pop);

	always_ff @(posedge clk_sys) begin
		if (push)
			q_mem[wr_ptr] <= in_req;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (deq)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !deq)
				count <= count + 1'b1;
			else if (deq && !push)
				count <= count - 1'b1;
		end
	end

	// Optional ROM pages, lowest register bit wins
	always_comb begin
		rom_hit  = 1'b1;
		rom_base = ROM_P10;
		if (page_reg[0] && rom_avail[0])
			rom_base = ROM_P10;
		else if (page_reg[1] && rom_avail[1])
			rom_base = ROM_P11;
		else if (page_reg[3] && rom_avail[2])
			rom_base = ROM_P12;
		else if (page_reg[4] && rom_avail[3])
			rom_base = ROM_P13;
		else
			rom_hit = 1'b0;
	end

	always_comb begin
		is_sys = (head.addr == SYSREG_ADDR);
		case (head.addr[15:14])
			2'b00:   phys = RAM_PAGE_BASE[0] | phys_addr_t'(head.addr[13:0]);
			2'b01:   phys = page_base(page_reg[14:12]) | phys_addr_t'(head.addr[13:0]);
			2'b10:   phys = (rom_hit ? rom_base : page_base(page_reg[10:8]))
			              | phys_addr_t'(head.addr[13:0]);
			default: phys = (head.addr[13] ? MSTD_BASE : BIOS11_BASE)
			              | phys_addr_t'(head.addr[12:0]);
		endcase

		if (head.we) begin
			if (is_sys)
				kind = ACC_SYSREG;
			else if (phys >= ROM_START || head.addr >= IO_START)
				kind = ACC_ERR;  // ROM is read only, I/O is not here
			else
				kind = ACC_WRITE;
		end else begin
			kind = (head.addr >= TOP_ADDR || is_sys) ? ACC_ERR : ACC_READ;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc.valid     <= 1'b0;
			credit_return <= 1'b0;
			page_reg      <= '0;
		end else begin
			credit_return <= pop;
			if (pop)
				acc.valid <= 1'b1;
			else if (acc.ready)
				acc.valid <= 1'b0;
			// Bit 11 marks a page switch write
			if (pop && kind == ACC_SYSREG && head.wtbt[1] && head.din[11])
				page_reg <= head.din;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pop) begin
			acc.kind  <= kind;
			acc.phys  <= phys;
			acc.be    <= head.we ? head.wtbt : 2'b11;
			acc.wdata <= head.din;
		end
	end

endmodule

`default_nettype wire

// File: mem_execute.sv
// Physical memory and ROM loader
`default_nettype none

module mem_execute import bk_mem_pkg::*; (
	input  wire             clk_sys,
	input  wire             rst_n,
	input  wire             load_we,
	input  wire phys_addr_t load_addr,
	input  wire bus_word_t  load_din,
	output logic [3:0]      rom_avail,
	acc_if.exe              acc,
	res_if.exe              res
);

	localparam int WORDS = 1 << (PHYS_AW - 1);  // 512K words

	logic [1:0][7:0]      mem [WORDS];
	logic [PHYS_AW-2:0]   acc_idx, load_idx;
	logic                 fire;
	logic                 load_nz;

	assign acc.ready = !load_we;  // Loader owns the port
	assign fire      = acc.valid && acc.ready;
	assign acc_idx   = acc.phys[PHYS_AW-1:1];
	assign load_idx  = load_addr[PHYS_AW-1:1];
	assign load_nz   = |load_din;

	// Single port array, loader first
	always_ff @(posedge clk_sys) begin
		if (load_we) begin
			mem[load_idx] <= load_din;
		end else if (fire) begin
			if (acc.kind == ACC_WRITE) begin
				if (acc.be[0])
					mem[acc_idx][0] <= acc.wdata[7:0];
				if (acc.be[1])
					mem[acc_idx][1] <= acc.wdata[15:8];
			end
			res.rdata <= mem[acc_idx];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fire) begin
			res.kind  <= acc.kind;
			res.phys  <= acc.phys;
			res.be    <= acc.be;
			res.wdata <= acc.wdata;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			res.valid <= 1'b0;
			rom_avail <= '0;
		end else begin
			res.valid <= fire;
			// A ROM page counts as present once real data lands in it
			if (load_we) begin
				case (load_addr[PHYS_AW-1:PAGE_SHIFT])
					ROM_P10[PHYS_AW-1:PAGE_SHIFT]: rom_avail[0] <= rom_avail[0] | load_nz;
					ROM_P11[PHYS_AW-1:PAGE_SHIFT]: rom_avail[1] <= rom_avail[1] | load_nz;
					ROM_P12[PHYS_AW-1:PAGE_SHIFT]: rom_avail[2] <= rom_avail[2] | load_nz;
					ROM_P13[PHYS_AW-1:PAGE_SHIFT]: rom_avail[3] <= rom_avail[3] | load_nz;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_result.sv
// Bus response and screen buffer
`default_nettype none

module bus_result import bk_mem_pkg::*; (
	input  wire               clk_sys,
	input  wire               rst_n,
	res_if.res                res,
	output logic              rsp_valid,
	output bus_word_t         rsp_data,
	output logic              rsp_err,
	input  wire [SCR_AW-1:0]  scr_addr,
	output bus_word_t         scr_data
);

	logic [1:0][7:0]           scr_mem [1 << SCR_AW];
	logic [PHYS_AW-PAGE_SHIFT-1:0] page;
	logic                      scr0_hit, scr1_hit, scr_we;
	logic [SCR_AW-1:0]         scr_wa;

	assign page     = res.phys[PHYS_AW-1:PAGE_SHIFT];
	assign scr0_hit = (page == SCR_PAGE_0);
	assign scr1_hit = (page == SCR_PAGE_1);
	assign scr_we   = res.valid && res.kind == ACC_WRITE && (scr0_hit || scr1_hit);
	assign scr_wa   = {scr1_hit, res.phys[PAGE_SHIFT-1:1]};  // Page 6 in the upper half

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= res.valid;
	end

	always_ff @(posedge clk_sys) begin
		if (res.valid) begin
			rsp_err  <= (res.kind == ACC_ERR);
			rsp_data <= (res.kind == ACC_READ) ? res.rdata : '0;
		end
	end

	// Write mirror of the video pages
	always_ff @(posedge clk_sys) begin
		if (scr_we) begin
			if (res.be[0])
				scr_mem[scr_wa][0] <= res.wdata[7:0];
			if (res.be[1])
				scr_mem[scr_wa][1] <= res.wdata[15:8];
		end
	end

	always_ff @(posedge clk_sys) begin
		scr_data <= scr_mem[scr_addr];  // Display read port
	end

endmodule

`default_nettype wire

// File: bk_mem_top.sv
// BK0011M memory mapper top
`default_nettype none

module bk_mem_top import bk_mem_pkg::*; (
	input  wire               clk_sys,
	input  wire               rst_n,

	input  wire               req_valid,
	input  wire               req_we,
	input  wire [1:0]         req_wtbt,
	input  wire [BUS_AW-1:0]  req_addr,
	input  wire bus_word_t    req_din,
	output logic              credit_return,

	output logic              rsp_valid,
	output bus_word_t         rsp_data,
	output logic              rsp_err,

	input  wire               load_we,
	input  wire phys_addr_t   load_addr,
	input  wire bus_word_t    load_din,

	input  wire [SCR_AW-1:0]  scr_addr,
	output bus_word_t         scr_data
);

	logic [3:0] rom_avail;

	acc_if acc ();
	res_if res ();

	page_decode u_decode (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.req_valid     (req_valid),
		.req_we        (req_we),
		.req_wtbt      (req_wtbt),
		.req_addr      (req_addr),
		.req_din       (req_din),
		.credit_return (credit_return),
		.rom_avail     (rom_avail),
		.acc           (acc.dec)
	);

	mem_execute u_execute (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.load_we   (load_we),
		.load_addr (load_addr),
		.load_din  (load_din),
		.rom_avail (rom_avail),
		.acc       (acc.exe),
		.res       (res.exe)
	);

	bus_result u_result (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.res       (res.res),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_err   (rsp_err),
		.scr_addr  (scr_addr),
		.scr_data  (scr_data)
	);

endmodule

`default_nettype wire

// File: bk_mem_chk.sv
// Credit and reset assertions
`default_nettype none

module bk_mem_chk import bk_mem_pkg::*; (
	input wire clk_sys,
	input wire rst_n,
	input wire req_valid,
	input wire credit_return,
	input wire rsp_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	int taken, returned;
	int fails = 0;  // Failed assertion count

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			taken    <= 0;
			returned <= 0;
		end else begin
			taken    <= taken + int'(req_valid);
			returned <= returned + int'(credit_return);
		end
	end

	a_credit_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		req_valid |-> (taken - returned) < REQ_CREDITS)
		else begin
			fails++;
			$error("request sent without a credit");
		end

	a_return_bound: assert property (@(posedge clk_sys) disable iff (!rst_n)
		returned <= taken)
		else begin
			fails++;
			$error("more credits returned than requests taken");
		end

	// Response stays quiet while reset is held
	a_rsp_reset: assert property (@(posedge clk_sys) !rst_n |-> !rsp_valid)
		else begin
			fails++;
			$error("rsp_valid high during reset");
		end

	// Credits at the requester once this cycle's return lands
	a_credit_max: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(REQ_CREDITS - taken + returned + int'(credit_return)) <= REQ_CREDITS)
		else begin
			fails++;
			$error("credit count above the queue depth");
		end

endmodule

bind bk_mem_top bk_mem_chk u_chk (
	.clk_sys       (clk_sys),
	.rst_n         (rst_n),
	.req_valid     (req_valid),
	.credit_return (credit_return),
	.rsp_valid     (rsp_valid)
);

`default_nettype wire

// File: tb_bk_mem.sv
// Memory mapper testbench
`default_nettype none

module tb_bk_mem import bk_mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_MAX = 300;
	localparam int CODE_PAGE [8] = '{1, 5, 2, 3, 4, 7, 0, 6};  // Indexed by page code
	localparam int REG_BIT [4] = '{0, 1, 3, 4};

	typedef struct packed {
		logic      err;
		bus_word_t data;
	} exp_t;

	logic              clk_sys, rst_n;
	logic              req_valid, req_we;
	logic [1:0]        req_wtbt;
	logic [BUS_AW-1:0] req_addr;
	bus_word_t         req_din;
	logic              credit_return;
	logic              rsp_valid, rsp_err;
	bus_word_t         rsp_data;
	logic              load_we;
	phys_addr_t        load_addr;
	bus_word_t         load_din;
	logic [SCR_AW-1:0] scr_addr;
	bus_word_t         scr_data;

	exp_t              exp_q [$];
	bus_word_t         shadow [int];  // Word-indexed physical memory
	logic [15:0]       tb_page;
	logic [3:0]        tb_avail;
	int                credits, errors, checks, tests, test_err0;
	bit                starved;
	string             cur_test;
	int                seed = 32'he29d0694;
	logic [BUS_AW-1:0] addrs [16];

	bk_mem_top u_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		#2_000_000;
		$display("Simulation stopped at the time limit");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check_word(input string what, input bus_word_t exp, input bus_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_err(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	// Credits and responses, sampled mid-cycle
	always @(negedge clk_sys) begin
		exp_t e;
		if (rst_n === 1'b1 && credit_return === 1'b1)
			credits++;
		if (rst_n === 1'b1 && rsp_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: a response arrived with no request outstanding", cur_test);
			end else begin
				e = exp_q.pop_front();
				check_err("rsp_err", e.err, rsp_err);
				check_word("rsp_data", e.data, rsp_data);
			end
		end
	end

	function automatic bus_word_t fill_word(input phys_addr_t a);
		logic [18:0] w;
		w = a[19:1];
		return w[15:0] ^ {w[18:16], w[18:6]} ^ 16'hA5C3;
	endfunction

	function automatic phys_addr_t ref_phys(input logic [15:0] a);
		phys_addr_t base;
		case (a[15:14])
			2'b00: base = 20'h00000;
			2'b01: base = phys_addr_t'(CODE_PAGE[tb_page[14:12]]) << 14;
			2'b10: begin
				if (tb_page[0] && tb_avail[0])
					base = ROM_P10;
				else if (tb_page[1] && tb_avail[1])
					base = ROM_P11;
				else if (tb_page[3] && tb_avail[2])
					base = ROM_P12;
				else if (tb_page[4] && tb_avail[3])
					base = ROM_P13;
				else
					base = phys_addr_t'(CODE_PAGE[tb_page[10:8]]) << 14;
			end
			default: return (a[13] ? MSTD_BASE : BIOS11_BASE) + phys_addr_t'(a[12:0]);
		endcase
		return base + phys_addr_t'(a[13:0]);
	endfunction

	// Reference outcome of one bus request
	task automatic predict(input logic we, input logic [1:0] wtbt, input logic [15:0] a,
			input bus_word_t d);
		phys_addr_t p;
		int         w;
		bus_word_t  cur;
		logic       err;
		bus_word_t  data;
		p    = ref_phys(a);
		w    = int'(p >> 1);
		err  = 1'b0;
		data = '0;
		cur  = shadow.exists(w) ? shadow[w] : 16'hxxxx;
		if (we && a == SYSREG_ADDR) begin
			if (wtbt[1] && d[11])
				tb_page = d;
		end else if (we && (p >= ROM_START || a >= IO_START)) begin
			err = 1'b1;
		end else if (we) begin
			if (wtbt[0])
				cur[7:0] = d[7:0];
			if (wtbt[1])
				cur[15:8] = d[15:8];
			shadow[w] = cur;
		end else if (a >= TOP_ADDR) begin
			err = 1'b1;  // Page register reads land here too
		end else begin
			data = cur;
		end
		exp_q.push_back({err, data});
	endtask

	task automatic send(input logic we, input logic [1:0] wtbt, input logic [15:0] a,
			input bus_word_t d);
		int waited;
		waited = 0;
		@(posedge clk_sys);
		#2;
		req_valid = 1'b0;
		while (credits == 0 && waited < WAIT_MAX) begin
			@(posedge clk_sys);
			#2;
			waited++;
		end
		if (waited > 0)
			starved = 1'b1;
		if (credits == 0) begin
			errors++;
			$display("%s: no credit came back within %0d cycles", cur_test, WAIT_MAX);
		end else begin
			req_valid = 1'b1;
			req_we    = we;
			req_wtbt  = wtbt;
			req_addr  = a;
			req_din   = d;
			credits--;
			predict(we, wtbt, a, d);
		end
	endtask

	task automatic wr(input logic [15:0] a, input bus_word_t d);
		send(1'b1, 2'b11, a, d);
	endtask

	task automatic rd(input logic [15:0] a);
		send(1'b0, 2'b00, a, '0);
	endtask

	task automatic load_word(input phys_addr_t a, input bus_word_t d);
		@(posedge clk_sys);
		#2;
		load_we   = 1'b1;
		load_addr = a;
		load_din  = d;
		shadow[int'(a >> 1)] = d;
		if (d != '0 && a >= ROM_P10 && a < BIOS11_BASE)
			tb_avail[a[15:14]] = 1'b1;  // Non-zero data exposes the ROM page
	endtask

	task automatic load_fill(input phys_addr_t a);
		load_word(a, fill_word(a));
	endtask

	task automatic load_end;
		@(posedge clk_sys);
		#2;
		load_we = 1'b0;
	endtask

	task automatic drain;
		int waited;
		waited = 0;
		@(posedge clk_sys);
		#2;
		req_valid = 1'b0;
		while (exp_q.size() != 0 && waited < WAIT_MAX) begin
			@(posedge clk_sys);
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%s: %0d responses never arrived", cur_test, exp_q.size());
			exp_q.delete();
		end
		@(negedge clk_sys);
		if (credits != REQ_CREDITS) begin
			errors++;
			$display("%s: %0d credits held after the queue drained", cur_test, credits);
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_err0 = errors;
		tests++;
	endtask

	task automatic finish_test;
		drain();
		if (errors == test_err0)
			$display("test %-13s passed", cur_test);
		else
			$display("test %-13s %0d errors", cur_test, errors - test_err0);
	endtask

	task automatic check_screen(input logic [SCR_AW-1:0] idx, input bus_word_t exp);
		@(posedge clk_sys);
		#2;
		scr_addr = idx;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_word("scr_data", exp, scr_data);
	endtask

	task automatic readback;
		start_test("readback");
		for (int i = 0; i < 16; i++) begin
			addrs[i] = {2'b00, 13'($random(seed)), 1'b0};
			wr(addrs[i], bus_word_t'($random(seed)));
		end
		for (int i = 0; i < 16; i++)
			send(1'b1, 2'(i), addrs[i], bus_word_t'($random(seed)));  // Every lane pattern
		for (int i = 0; i < 16; i++)
			rd(addrs[i]);
		finish_test();
	endtask

	task automatic page_select;
		start_test("page_select");
		for (int p = 0; p < 8; p++)
			load_fill((phys_addr_t'(p) << 14) | 20'h00100);
		load_end();
		for (int c = 0; c < 8; c++) begin
			wr(SYSREG_ADDR, 16'h0800 | bus_word_t'(c << 12));
			rd(16'h4100);
		end
		send(1'b1, 2'b11, SYSREG_ADDR, 16'h3000);  // Bit 11 clear
		rd(16'h4100);
		send(1'b1, 2'b01, SYSREG_ADDR, 16'h3800);  // High lane off
		rd(16'h4100);
		finish_test();
	endtask

	task automatic rom_pages;
		phys_addr_t rom_base [4];
		rom_base = '{ROM_P10, ROM_P11, ROM_P12, ROM_P13};
		start_test("rom_pages");
		load_fill(20'h08040);
		load_word(ROM_P10 | 20'h00040, 16'h0000);  // Zero data keeps the page hidden
		load_end();
		wr(SYSREG_ADDR, 16'h0A01);
		rd(16'h8040);
		for (int j = 0; j < 4; j++) begin
			drain();
			load_word(rom_base[j] | 20'h00040, fill_word(rom_base[j]) | 16'h8000);
			load_end();
			wr(SYSREG_ADDR, 16'h0A00 | (16'h0001 << REG_BIT[j]));
			rd(16'h8040);
			wr(16'h8040, 16'h5555);
		end
		wr(SYSREG_ADDR, 16'h0A00);
		rd(16'h8040);
		finish_test();
	endtask

	task automatic error_map;
		start_test("error_map");
		load_fill(BIOS11_BASE | 20'h00200);
		load_fill(MSTD_BASE | 20'h00200);
		load_end();
		rd(16'hC200);
		rd(16'hE200);
		wr(16'hC200, 16'h1111);
		wr(IO_START, 16'h2222);
		wr(16'o177714, 16'h3333);
		rd(TOP_ADDR);
		rd(SYSREG_ADDR);
		finish_test();
	endtask

	task automatic backpressure;
		start_test("backpressure");
		starved = 1'b0;
		fork
			begin
				for (int i = 0; i < 16; i++)
					load_fill(20'h1C000 + phys_addr_t'(2 * i));
				load_end();
			end
			begin
				repeat (2) @(posedge clk_sys);
				for (int i = 0; i < 4; i++)
					wr(addrs[i], bus_word_t'($random(seed)));
				for (int i = 0; i < 4; i++)
					rd(addrs[i]);
			end
		join
		if (!starved) begin
			errors++;
			$display("%s: credits never ran out while the loader held the port", cur_test);
		end
		finish_test();
	endtask

	task automatic screen_mirror;
		logic [SCR_AW-1:0] idx [8];
		bus_word_t         val [8];
		logic [12:0]       woff;
		start_test("screen");
		for (int i = 0; i < 8; i++) begin
			if (i == 0)
				wr(SYSREG_ADDR, 16'h1800);  // Window 01 on page 5
			if (i == 4)
				wr(SYSREG_ADDR, 16'h7800);  // Window 01 on page 6
			woff   = {2'(i), 11'($random(seed))};
			idx[i] = {i >= 4, woff};
			val[i] = bus_word_t'($random(seed));
			wr(16'h4000 | {2'b00, woff, 1'b0}, val[i]);
		end
		drain();
		for (int i = 0; i < 8; i++)
			check_screen(idx[i], val[i]);
		finish_test();
	endtask

	initial begin
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_we    = 1'b0;
		req_wtbt  = '0;
		req_addr  = '0;
		req_din   = '0;
		load_we   = 1'b0;
		load_addr = '0;
		load_din  = '0;
		scr_addr  = '0;
		credits   = REQ_CREDITS;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		tb_page   = '0;
		tb_avail  = '0;
		starved   = 1'b0;
		cur_test  = "reset";
		repeat (8) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;
		readback();
		page_select();
		rom_pages();
		error_map();
		backpressure();
		screen_mirror();
		errors += u_dut.u_chk.fails;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
bk_mem_pkg.sv
bk_mem_if.sv
page_decode.sv
mem_execute.sv
bus_result.sv
bk_mem_top.sv
bk_mem_chk.sv
tb_bk_mem.sv

// File: Bender.yml
package:
  name: bk_mem

sources:
  - bk_mem_pkg.sv
  - bk_mem_if.sv
  - page_decode.sv
  - mem_execute.sv
  - bus_result.sv
  - bk_mem_top.sv
  - target: test
    files:
      - bk_mem_chk.sv
      - tb_bk_mem.sv
